/* flist.f */
common/core_pkg.sv
common/fwd_if.sv
verilog/pipe_stage.sv
verilog/regfile.sv
verilog/ifetch.sv
decode/core_decode.sv
verilog/core_execute.sv
verilog/core_result.sv
verilog/cpu_top.sv
sim/tb_cpu_asserts.sv
sim/tb_cpu.sv

/* sim/tb_cpu.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_cpu;

  localparam logic [31:0] MARKER  = 32'h0000_03fc;
  localparam int          TIMEOUT = 2000;
  localparam logic [31:0] NOP     = 32'h0000_0013;
  localparam logic [6:0]  OPC_IMM  = 7'b0010011;
  localparam logic [6:0]  OPC_LOAD = 7'b0000011;

  logic        clk;
  logic        rstn;
  logic [31:0] inst_in;
  logic        inst_read;
  logic [31:0] inst_addr;
  logic [31:0] data_in;
  logic        data_read;
  logic [3:0]  data_read_type;
  logic        data_write;
  logic [3:0]  data_write_type;
  logic [31:0] data_write_addr;
  logic [31:0] data_out;
  logic        stall_imem;
  logic        stall_dmem;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  int          n_inst;
  int          errors;
  logic        marker_seen;
  logic [31:0] rng;
  logic [31:0] rec_addr[$];
  logic [31:0] rec_data[$];
  logic [3:0]  rec_be[$];
  logic [31:0] exp_addr[$];
  logic [31:0] exp_data[$];
  logic [3:0]  exp_be[$];
  logic [31:0] rec_rd_addr[$];
  logic [3:0]  rec_rd_be[$];
  logic [31:0] exp_rd_addr[$];
  logic [3:0]  exp_rd_be[$];

  cpu_top dut (
    .clk               (clk),
    .rstn              (rstn),
    .inst_in_i         (inst_in),
    .inst_read_o       (inst_read),
    .inst_addr_o       (inst_addr),
    .data_in_i         (data_in),
    .data_read_o       (data_read),
    .data_read_type_o  (data_read_type),
    .data_write_o      (data_write),
    .data_write_type_o (data_write_type),
    .data_write_addr_o (data_write_addr),
    .data_out_o        (data_out),
    .stallreq_from_imem(stall_imem),
    .stallreq_from_dmem(stall_dmem)
  );

  always #4 clk = ~clk;

  // Combinational instruction memory
  assign inst_in = imem[inst_addr[9:2]];

  // Data memory acts only in cycles where the pipeline advances, and logs each access
  always @(posedge clk) begin
    if (rstn && !stall_dmem && !stall_imem) begin
      if (data_write) begin
        for (int b = 0; b < 4; b++) begin
          if (data_write_type[b]) begin
            dmem[data_write_addr[9:2]][8*b +: 8] = data_out[8*b +: 8];
          end
        end
        rec_addr.push_back(data_write_addr);
        rec_data.push_back(data_out);
        rec_be.push_back(data_write_type);
        if (data_write_addr == MARKER) begin
          marker_seen = 1'b1;
        end
      end
      if (data_read) begin
        data_in <= #1 dmem[data_write_addr[9:2]];
        rec_rd_addr.push_back(data_write_addr);
        rec_rd_be.push_back(data_read_type);
      end
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] r_type(input logic [2:0] f3, input logic [6:0] f7,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input int imm);
    logic [31:0] o;
    o = imm;
    return {o[11:0], rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [2:0] f3, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input int imm);
    logic [31:0] o;
    o = imm;
    return {o[11:5], rs2, rs1, f3, o[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input int off);
    logic [31:0] o;
    o = off;
    return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] j_type(input logic [4:0] rd, input int off);
    logic [31:0] o;
    o = off;
    return {o[20], o[10:1], o[11], o[19:12], rd, 7'b1101111};
  endfunction

  task automatic emit(input logic [31:0] word);
    imem[n_inst] = word;
    n_inst++;
  endtask

  task automatic expect_store(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] be);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
    exp_be.push_back(be);
  endtask

  task automatic expect_read(input logic [31:0] addr, input logic [3:0] be);
    exp_rd_addr.push_back(addr);
    exp_rd_be.push_back(be);
  endtask

  task automatic clear_program();
    for (int i = 0; i < 256; i++) begin
      imem[i] = NOP;
    end
    n_inst = 0;
    exp_addr.delete();
    exp_data.delete();
    exp_be.delete();
    exp_rd_addr.delete();
    exp_rd_be.delete();
  endtask

  // Marker store ends the test, then the core spins on itself
  task automatic finish_program(input logic [4:0] rs, input logic [31:0] value);
    emit(s_type(3'b010, rs, 0, int'(MARKER)));
    expect_store(MARKER, value, 4'b1111);
    emit(j_type(0, 0));
  endtask

  task automatic preload_data();
    for (int i = 0; i < 256; i++) begin
      dmem[i] = 32'hc0de_0000 | i;
    end
  endtask

  task automatic reset_core();
    rstn = 1'b0;
    stall_imem = 1'b0;
    stall_dmem = 1'b0;
    marker_seen = 1'b0;
    rec_addr.delete();
    rec_data.delete();
    rec_be.delete();
    rec_rd_addr.delete();
    rec_rd_be.delete();
    repeat (10) @(posedge clk);
    #1;
    rstn = 1'b1;
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
  endtask

  task automatic wait_for_marker(input logic stalled);
    int n;
    n = 0;
    while (!marker_seen && n < TIMEOUT) begin
      @(posedge clk);
      #1;
      if (stalled) begin
        rng = xorshift32(rng);
        stall_imem = (rng[1:0] == 2'b00);
        stall_dmem = (rng[5:4] == 2'b00);
      end
      n++;
    end
    stall_imem = 1'b0;
    stall_dmem = 1'b0;
    if (!marker_seen) begin
      errors++;
      $display("%0t timed out waiting for the marker store", $time);
    end
  endtask

  task automatic compare_stores(input string tag);
    int n;
    n = (rec_addr.size() < exp_addr.size()) ? rec_addr.size() : exp_addr.size();
    if (rec_addr.size() != exp_addr.size()) begin
      errors++;
      $display("%0t %s saw %0d stores but expected %0d", $time, tag,
               rec_addr.size(), exp_addr.size());
    end
    for (int i = 0; i < n; i++) begin
      if (rec_addr[i] !== exp_addr[i]) begin
        report_mismatch($sformatf("%s store %0d data_write_addr_o", tag, i),
                        rec_addr[i], exp_addr[i]);
      end
      if (rec_data[i] !== exp_data[i]) begin
        report_mismatch($sformatf("%s store %0d data_out_o", tag, i), rec_data[i], exp_data[i]);
      end
      if (rec_be[i] !== exp_be[i]) begin
        report_mismatch($sformatf("%s store %0d data_write_type_o", tag, i),
                        32'(rec_be[i]), 32'(exp_be[i]));
      end
    end
  endtask

  task automatic compare_reads(input string tag);
    int n;
    n = (rec_rd_addr.size() < exp_rd_addr.size()) ? rec_rd_addr.size()
                                                   : exp_rd_addr.size();
    if (rec_rd_addr.size() != exp_rd_addr.size()) begin
      errors++;
      $display("%0t %s saw %0d loads but expected %0d", $time, tag,
               rec_rd_addr.size(), exp_rd_addr.size());
    end
    for (int i = 0; i < n; i++) begin
      if (rec_rd_addr[i] !== exp_rd_addr[i]) begin
        report_mismatch($sformatf("%s load %0d data_write_addr_o", tag, i),
                        rec_rd_addr[i], exp_rd_addr[i]);
      end
      if (rec_rd_be[i] !== exp_rd_be[i]) begin
        report_mismatch($sformatf("%s load %0d data_read_type_o", tag, i),
                        32'(rec_rd_be[i]), 32'(exp_rd_be[i]));
      end
    end
  endtask

  task automatic after_reset();
    int n;
    clear_program();
    emit(i_type(OPC_IMM, 3'b000, 1, 0, 1));
    emit(i_type(OPC_IMM, 3'b000, 2, 1, 2));
    emit(i_type(OPC_IMM, 3'b000, 3, 2, 3));
    finish_program(3, 32'd6);
    preload_data();
    reset_core();
    if (inst_addr !== 32'h0) begin
      report_mismatch("inst_addr_o", inst_addr, 32'h0);
    end
    n = 0;
    while (data_write !== 1'b1 && n < TIMEOUT) begin
      if (data_read !== 1'b0) begin
        report_mismatch("data_read_o", 32'(data_read), 32'h0);
      end
      @(posedge clk);
      #1;
      if (inst_read !== 1'b1) begin
        report_mismatch("inst_read_o", 32'(inst_read), 32'h1);
      end
      n++;
    end
    if (data_write !== 1'b1) begin
      errors++;
      $display("%0t no data write seen after reset", $time);
    end
    wait_for_marker(1'b0);
    compare_stores("after reset");
    compare_reads("after reset");
  endtask

  task automatic build_chain();
    logic [31:0] r1, r2, r3, r4, r5, r6, r7, r8, r9, r10;
    clear_program();
    r1  = 32'd5;
    r2  = r1 + 32'd7;
    r3  = r1 + r2;
    r4  = r3 - r1;
    r5  = r4 ^ r3;
    r6  = 32'(-3);
    r7  = ($signed(r6) < $signed(r5)) ? 32'd1 : 32'd0;
    r8  = r5 & r6;
    r9  = r8 | r7;
    r10 = r9 + 32'(-100);
    emit(i_type(OPC_IMM, 3'b000, 1, 0, 5));
    emit(i_type(OPC_IMM, 3'b000, 2, 1, 7));
    emit(r_type(3'b000, 7'h00, 3, 1, 2));
    emit(r_type(3'b000, 7'h20, 4, 3, 1));
    emit(r_type(3'b100, 7'h00, 5, 4, 3));
    emit(i_type(OPC_IMM, 3'b000, 6, 0, -3));
    emit(r_type(3'b010, 7'h00, 7, 6, 5));
    emit(r_type(3'b111, 7'h00, 8, 5, 6));
    emit(r_type(3'b110, 7'h00, 9, 8, 7));
    emit(i_type(OPC_IMM, 3'b000, 10, 9, -100));
    emit(s_type(3'b010, 10, 0, 'h10c));
    emit(s_type(3'b010, 5, 0, 'h100));
    emit(s_type(3'b010, 7, 0, 'h104));
    emit(s_type(3'b010, 9, 0, 'h108));
    expect_store(32'h10c, r10, 4'b1111);
    expect_store(32'h100, r5, 4'b1111);
    expect_store(32'h104, r7, 4'b1111);
    expect_store(32'h108, r9, 4'b1111);
    finish_program(0, 32'h0);
  endtask

  task automatic forward_chain();
    build_chain();
    preload_data();
    reset_core();
    wait_for_marker(1'b0);
    compare_stores("forwarding chain");
    compare_reads("forwarding chain");
  endtask

  task automatic load_use();
    clear_program();
    emit(i_type(OPC_IMM, 3'b000, 1, 0, 100));
    emit(i_type(OPC_LOAD, 3'b010, 2, 0, 'h40));
    emit(r_type(3'b000, 7'h00, 3, 2, 1));
    emit(s_type(3'b010, 3, 0, 'h110));
    emit(i_type(OPC_LOAD, 3'b010, 4, 0, 'h44));
    emit(NOP);
    emit(r_type(3'b000, 7'h00, 5, 1, 4));
    emit(s_type(3'b010, 5, 0, 'h114));
    emit(i_type(OPC_LOAD, 3'b010, 6, 0, 'h48));
    emit(s_type(3'b010, 6, 0, 'h118));
    preload_data();
    dmem[16] = 32'h1234_5678;
    dmem[17] = 32'hffff_fff0;
    dmem[18] = 32'h0bad_cafe;
    expect_read(32'h40, 4'b1111);
    expect_read(32'h44, 4'b1111);
    expect_read(32'h48, 4'b1111);
    expect_store(32'h110, dmem[16] + 32'd100, 4'b1111);
    expect_store(32'h114, dmem[17] + 32'd100, 4'b1111);
    expect_store(32'h118, dmem[18], 4'b1111);
    finish_program(0, 32'h0);
    reset_core();
    wait_for_marker(1'b0);
    compare_stores("load use");
    compare_reads("load use");
  endtask

  task automatic byte_lanes();
    int          imms[4];
    int          offs[6];
    bit          uns[6];
    logic [7:0]  b[4];
    logic [31:0] val;
    imms = '{129, 127, 90, -1};
    offs = '{0, 0, 1, 3, 3, 2};
    uns  = '{0, 1, 0, 1, 0, 0};
    clear_program();
    for (int k = 0; k < 4; k++) begin
      b[k] = imms[k][7:0];
      emit(i_type(OPC_IMM, 3'b000, 5'(k + 1), 0, imms[k]));
    end
    for (int k = 0; k < 4; k++) begin
      emit(s_type(3'b000, 5'(k + 1), 0, 'h200 + k));
      expect_store(32'h200 + k, {4{b[k]}}, 4'b0001 << k);
    end
    // Each load is stored by the very next instruction
    for (int j = 0; j < 6; j++) begin
      emit(i_type(OPC_LOAD, uns[j] ? 3'b100 : 3'b000, 5'(j + 5), 0, 'h200 + offs[j]));
      emit(s_type(3'b010, 5'(j + 5), 0, 'h120 + 4 * j));
      expect_read(32'h200 + offs[j], 4'b0001 << offs[j]);
      val = uns[j] ? {24'h0, b[offs[j]]} : {{24{b[offs[j]][7]}}, b[offs[j]]};
      expect_store(32'h120 + 4 * j, val, 4'b1111);
    end
    finish_program(0, 32'h0);
    preload_data();
    reset_core();
    wait_for_marker(1'b0);
    compare_stores("byte lanes");
    compare_reads("byte lanes");
  endtask

  task automatic branch_flush();
    logic [31:0] jal_pc;
    clear_program();
    emit(i_type(OPC_IMM, 3'b000, 1, 0, 7));
    emit(i_type(OPC_IMM, 3'b000, 2, 0, 7));
    emit(i_type(OPC_IMM, 3'b000, 3, 0, 9));
    emit(b_type(3'b000, 1, 2, 8));
    emit(s_type(3'b010, 1, 0, 'h140));
    emit(b_type(3'b001, 1, 2, 8));
    emit(s_type(3'b010, 2, 0, 'h144));
    emit(b_type(3'b001, 1, 3, 8));
    emit(s_type(3'b010, 3, 0, 'h148));
    emit(b_type(3'b000, 1, 3, 8));
    emit(s_type(3'b010, 3, 0, 'h14c));
    jal_pc = 32'(n_inst * 4);
    emit(j_type(5, 8));
    emit(s_type(3'b010, 3, 0, 'h150));
    emit(s_type(3'b010, 5, 0, 'h154));
    // Only the stores behind not-taken branches and the link value
    expect_store(32'h144, 32'd7, 4'b1111);
    expect_store(32'h14c, 32'd9, 4'b1111);
    expect_store(32'h154, jal_pc + 32'd4, 4'b1111);
    finish_program(0, 32'h0);
    preload_data();
    reset_core();
    wait_for_marker(1'b0);
    compare_stores("branches");
    compare_reads("branches");
  endtask

  task automatic stalled_chain();
    build_chain();
    preload_data();
    reset_core();
    wait_for_marker(1'b1);
    compare_stores("stalled chain");
    compare_reads("stalled chain");
  endtask

  initial begin
    clk = 1'b0;
    rstn = 1'b0;
    stall_imem = 1'b0;
    stall_dmem = 1'b0;
    data_in = 32'h0;
    errors = 0;
    n_inst = 0;
    marker_seen = 1'b0;
    rng = 32'h989412d0;
    after_reset();
    forward_chain();
    load_use();
    byte_lanes();
    branch_flush();
    stalled_chain();
    $display("check errors: %0d, assertion failures: %0d", errors, dut.asserts0.fail_count);
    if (errors == 0 && dut.asserts0.fail_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/tb_cpu_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_cpu_asserts (
  input logic        clk,
  input logic        rstn,
  input logic [31:0] inst_addr_i,
  input logic        data_read_i,
  input logic        data_write_i,
  input logic [3:0]  data_write_type_i,
  input logic        stall_imem_i
);

  int fail_count = 0;

  assert property (@(posedge clk) disable iff (!rstn) !(data_read_i && data_write_i))
    else begin
      fail_count++;
      $error("data read and write strobes high together");
    end

  assert property (@(posedge clk) disable iff (!rstn)
                   data_write_i |-> (data_write_type_i == 4'b1111 || $onehot(data_write_type_i)))
    else begin
      fail_count++;
      $error("illegal write byte-enable %b", data_write_type_i);
    end

  assert property (@(posedge clk) disable iff (!rstn) inst_addr_i[1:0] == 2'b00)
    else begin
      fail_count++;
      $error("instruction address %h not word aligned", inst_addr_i);
    end

  // Fetch address frozen under an instruction memory stall
  assert property (@(posedge clk) disable iff (!rstn) stall_imem_i |=> $stable(inst_addr_i))
    else begin
      fail_count++;
      $error("instruction address moved during an imem stall");
    end

endmodule

bind cpu_top tb_cpu_asserts asserts0 (
  .clk              (clk),
  .rstn             (rstn),
  .inst_addr_i      (inst_addr_o),
  .data_read_i      (data_read_o),
  .data_write_i     (data_write_o),
  .data_write_type_i(data_write_type_o),
  .stall_imem_i     (stallreq_from_imem)
);

`default_nettype wire

/* verilog/cpu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_top (
  input  logic                      clk,
  input  logic                      rstn,
  // Instruction port
  input  logic [core_pkg::XLEN-1:0] inst_in_i,
  output logic                      inst_read_o,
  output logic [core_pkg::XLEN-1:0] inst_addr_o,
  // Data port
  input  logic [core_pkg::XLEN-1:0] data_in_i,
  output logic                      data_read_o,
  output logic [3:0]                data_read_type_o,
  output logic                      data_write_o,
  output logic [3:0]                data_write_type_o,
  output logic [core_pkg::XLEN-1:0] data_write_addr_o,
  output logic [core_pkg::XLEN-1:0] data_out_o,
  // Memory stall levels
  input  logic                      stallreq_from_imem,
  input  logic                      stallreq_from_dmem
);
  import core_pkg::*;

  if_id_t               if_d;
  if_id_t               if_q;
  id_ex_t               id_d;
  id_ex_t               id_q;
  ex_mem_t              ex_d;
  ex_mem_t              ex_q;
  mem_wb_t              mem_d;
  mem_wb_t              mem_q;
  logic [STAGE_NUM-1:0] hold;
  logic [STAGE_NUM-1:0] bubble;
  logic                 redirect;
  logic [XLEN-1:0]      target;
  logic [REG_AW-1:0]    raddr1;
  logic [REG_AW-1:0]    raddr2;
  logic [XLEN-1:0]      rdata1;
  logic [XLEN-1:0]      rdata2;
  logic                 rf_we;
  logic [REG_AW-1:0]    rf_waddr;
  logic [XLEN-1:0]      rf_wdata;

  fwd_if fwd ();

  // MEM forwarding straight from the EX/MEM register
  assign fwd.mem_wreg  = ex_q.wreg;
  assign fwd.mem_rd    = ex_q.rd;
  assign fwd.mem_data  = ex_q.result;
  assign fwd.mem_memrd = ex_q.memrd;

  ifetch ifetch0 (
    .clk        (clk),
    .rstn       (rstn),
    .hold_i     (hold[0]),
    .redirect_i (redirect),
    .target_i   (target),
    .inst_in_i  (inst_in_i),
    .inst_read_o(inst_read_o),
    .inst_addr_o(inst_addr_o),
    .fetch_o    (if_d)
  );

  pipe_stage #(.payload_t(if_id_t)) if_id0 (
    .clk(clk), .rstn(rstn), .hold_i(hold[1]), .bubble_i(bubble[1]), .d_i(if_d), .q_o(if_q)
  );

  regfile regfile0 (
    .clk     (clk),
    .rstn    (rstn),
    .we_i    (rf_we),
    .waddr_i (rf_waddr),
    .wdata_i (rf_wdata),
    .raddr1_i(raddr1),
    .raddr2_i(raddr2),
    .rdata1_o(rdata1),
    .rdata2_o(rdata2)
  );

  core_decode decode0 (
    .d_i            (if_q),
    .rs1_data_i     (rdata1),
    .rs2_data_i     (rdata2),
    .fwd            (fwd.dst),
    .stallreq_imem_i(stallreq_from_imem),
    .stallreq_dmem_i(stallreq_from_dmem),
    .raddr1_o       (raddr1),
    .raddr2_o       (raddr2),
    .e_o            (id_d),
    .redirect_o     (redirect),
    .target_o       (target),
    .hold_o         (hold),
    .bubble_o       (bubble)
  );

  pipe_stage #(.payload_t(id_ex_t)) id_ex0 (
    .clk(clk), .rstn(rstn), .hold_i(hold[2]), .bubble_i(bubble[2]), .d_i(id_d), .q_o(id_q)
  );

  core_execute execute0 (
    .e_i(id_q),
    .m_o(ex_d),
    .fwd(fwd.src)
  );

  pipe_stage #(.payload_t(ex_mem_t)) ex_mem0 (
    .clk(clk), .rstn(rstn), .hold_i(hold[3]), .bubble_i(bubble[3]), .d_i(ex_d), .q_o(ex_q)
  );

  core_result result0 (
    .m_i              (ex_q),
    .w_i              (mem_q),
    .data_in_i        (data_in_i),
    .data_read_o      (data_read_o),
    .data_read_type_o (data_read_type_o),
    .data_write_o     (data_write_o),
    .data_write_type_o(data_write_type_o),
    .data_write_addr_o(data_write_addr_o),
    .data_out_o       (data_out_o),
    .wb_o             (mem_d),
    .rf_we_o          (rf_we),
    .rf_waddr_o       (rf_waddr),
    .rf_wdata_o       (rf_wdata)
  );

  pipe_stage #(.payload_t(mem_wb_t)) mem_wb0 (
    .clk(clk), .rstn(rstn), .hold_i(hold[4]), .bubble_i(bubble[4]), .d_i(mem_d), .q_o(mem_q)
  );

endmodule

`default_nettype wire

/* verilog/core_result.sv */
`timescale 1ns/100ps
`default_nettype none

module core_result (
  input  core_pkg::ex_mem_t           m_i,
  input  core_pkg::mem_wb_t           w_i,
  input  logic [core_pkg::XLEN-1:0]   data_in_i,
  output logic                        data_read_o,
  output logic [3:0]                  data_read_type_o,
  output logic                        data_write_o,
  output logic [3:0]                  data_write_type_o,
  output logic [core_pkg::XLEN-1:0]   data_write_addr_o,
  output logic [core_pkg::XLEN-1:0]   data_out_o,
  output core_pkg::mem_wb_t           wb_o,
  output logic                        rf_we_o,
  output logic [core_pkg::REG_AW-1:0] rf_waddr_o,
  output logic [core_pkg::XLEN-1:0]   rf_wdata_o
);
  import core_pkg::*;

  logic [3:0]      be;
  logic [7:0]      ld_byte;
  logic [XLEN-1:0] ld_val;

  // MEM stage
  assign be = (m_i.func3 == F3_W) ? 4'b1111 : 4'b0001 << m_i.result[1:0];

  assign data_read_o       = m_i.memrd;
  assign data_write_o      = m_i.memwr;
  assign data_read_type_o  = m_i.memrd ? be : 4'b0000;
  assign data_write_type_o = m_i.memwr ? be : 4'b0000;
  assign data_write_addr_o = m_i.result;
  assign data_out_o = (m_i.func3 == F3_B) ? {4{m_i.store_data[7:0]}} : m_i.store_data;

  always_comb begin
    wb_o.result  = m_i.result;
    wb_o.rd      = m_i.rd;
    wb_o.wreg    = m_i.wreg;
    wb_o.memrd   = m_i.memrd;
    wb_o.func3   = m_i.func3;
    wb_o.addr_lo = m_i.result[1:0];
  end

  // WB stage
  assign ld_byte = data_in_i[8*w_i.addr_lo +: 8];

  always_comb begin
    case (w_i.func3)
      F3_B:    ld_val = {{(XLEN-8){ld_byte[7]}}, ld_byte};
      F3_BU:   ld_val = {{(XLEN-8){1'b0}}, ld_byte};
      default: ld_val = data_in_i;
    endcase
  end

  assign rf_we_o    = w_i.wreg;
  assign rf_waddr_o = w_i.rd;
  assign rf_wdata_o = w_i.memrd ? ld_val : w_i.result;

endmodule

`default_nettype wire

/* verilog/core_execute.sv */
`timescale 1ns/100ps
`default_nettype none

module core_execute (
  input  core_pkg::id_ex_t  e_i,
  output core_pkg::ex_mem_t m_o,
  fwd_if.src                fwd
);
  import core_pkg::*;

  logic [XLEN-1:0] alu;
  logic [XLEN-1:0] result;

  always_comb begin
    case (e_i.alu_op)
      ALU_SUB: alu = e_i.op_a - e_i.op_b;
      ALU_AND: alu = e_i.op_a & e_i.op_b;
      ALU_OR:  alu = e_i.op_a | e_i.op_b;
      ALU_XOR: alu = e_i.op_a ^ e_i.op_b;
      ALU_SLT: alu = XLEN'($signed(e_i.op_a) < $signed(e_i.op_b));
      default: alu = e_i.op_a + e_i.op_b;
    endcase
  end

  // Link address for JAL, otherwise ALU result or memory address
  assign result = e_i.is_link ? e_i.pc + XLEN'(4) : alu;

  always_comb begin
    m_o.result     = result;
    m_o.store_data = e_i.store_data;
    m_o.rd         = e_i.rd;
    m_o.wreg       = e_i.wreg;
    m_o.memrd      = e_i.memrd;
    m_o.memwr      = e_i.memwr;
    m_o.func3      = e_i.func3;
  end

  assign fwd.ex_wreg  = e_i.wreg;
  assign fwd.ex_rd    = e_i.rd;
  assign fwd.ex_data  = result;
  assign fwd.ex_memrd = e_i.memrd;

endmodule

`default_nettype wire

/* decode/core_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module core_decode (
  input  core_pkg::if_id_t                 d_i,
  input  logic [core_pkg::XLEN-1:0]        rs1_data_i,
  input  logic [core_pkg::XLEN-1:0]        rs2_data_i,
  fwd_if.dst                               fwd,
  input  logic                             stallreq_imem_i,
  input  logic                             stallreq_dmem_i,
  output logic [core_pkg::REG_AW-1:0]      raddr1_o,
  output logic [core_pkg::REG_AW-1:0]      raddr2_o,
  output core_pkg::id_ex_t                 e_o,
  output logic                             redirect_o,
  output logic [core_pkg::XLEN-1:0]        target_o,
  output logic [core_pkg::STAGE_NUM-1:0]   hold_o,
  output logic [core_pkg::STAGE_NUM-1:0]   bubble_o
);
  import core_pkg::*;

  logic [6:0]        opcode;
  logic [2:0]        func3;
  logic [REG_AW-1:0] rs1;
  logic [REG_AW-1:0] rs2;
  logic [REG_AW-1:0] rd;
  logic [XLEN-1:0]   imm_i;
  logic [XLEN-1:0]   imm_s;
  logic [XLEN-1:0]   imm_b;
  logic [XLEN-1:0]   imm_j;
  logic              ex_hit1;
  logic              ex_hit2;
  logic              mem_hit1;
  logic              mem_hit2;
  logic [XLEN-1:0]   src1;
  logic [XLEN-1:0]   src2;
  logic              use_rs1;
  logic              use_rs2;
  logic              is_branch;
  logic              is_jal;
  logic              taken;
  logic              load_use;
  logic              mem_stall;

  assign opcode = d_i.inst[6:0];
  assign func3  = d_i.inst[14:12];
  assign rd     = d_i.inst[11:7];
  assign rs1    = d_i.inst[19:15];
  assign rs2    = d_i.inst[24:20];

  assign imm_i = {{20{d_i.inst[31]}}, d_i.inst[31:20]};
  assign imm_s = {{20{d_i.inst[31]}}, d_i.inst[31:25], d_i.inst[11:7]};
  assign imm_b = {{19{d_i.inst[31]}}, d_i.inst[31], d_i.inst[7], d_i.inst[30:25],
                  d_i.inst[11:8], 1'b0};
  assign imm_j = {{11{d_i.inst[31]}}, d_i.inst[31], d_i.inst[19:12], d_i.inst[20],
                  d_i.inst[30:21], 1'b0};

  assign raddr1_o = rs1;
  assign raddr2_o = rs2;

  // wreg is never set for x0, so a hit implies a nonzero source
  assign ex_hit1  = fwd.ex_wreg && fwd.ex_rd == rs1;
  assign ex_hit2  = fwd.ex_wreg && fwd.ex_rd == rs2;
  assign mem_hit1 = fwd.mem_wreg && fwd.mem_rd == rs1;
  assign mem_hit2 = fwd.mem_wreg && fwd.mem_rd == rs2;

  assign src1 = ex_hit1 ? fwd.ex_data : mem_hit1 ? fwd.mem_data : rs1_data_i;
  assign src2 = ex_hit2 ? fwd.ex_data : mem_hit2 ? fwd.mem_data : rs2_data_i;

  always_comb begin
    e_o            = '0;
    e_o.pc         = d_i.pc;
    e_o.func3      = func3;
    e_o.rd         = rd;
    e_o.op_a       = src1;
    e_o.op_b       = imm_i;
    e_o.store_data = src2;
    use_rs1        = 1'b0;
    use_rs2        = 1'b0;
    is_branch      = 1'b0;
    is_jal         = 1'b0;
    case (opcode)
      OP_REG: begin
        use_rs1  = 1'b1;
        use_rs2  = 1'b1;
        e_o.op_b = src2;
        e_o.wreg = 1'b1;
        case (func3)
          3'b000:  e_o.alu_op = d_i.inst[30] ? ALU_SUB : ALU_ADD;
          3'b111:  e_o.alu_op = ALU_AND;
          3'b110:  e_o.alu_op = ALU_OR;
          3'b100:  e_o.alu_op = ALU_XOR;
          3'b010:  e_o.alu_op = ALU_SLT;
          default: e_o.wreg = 1'b0;
        endcase
      end
      OP_IMM: begin
        use_rs1  = 1'b1;
        e_o.wreg = (func3 == 3'b000);
      end
      OP_LOAD: begin
        use_rs1   = 1'b1;
        e_o.memrd = func3 inside {F3_B, F3_W, F3_BU};
        e_o.wreg  = e_o.memrd;
      end
      OP_STORE: begin
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
        e_o.op_b  = imm_s;
        e_o.memwr = func3 inside {F3_B, F3_W};
      end
      OP_BRANCH: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        // BEQ and BNE only
        is_branch = (func3[2:1] == 2'b00);
      end
      OP_JAL: begin
        is_jal      = 1'b1;
        e_o.wreg    = 1'b1;
        e_o.is_link = 1'b1;
      end
      default: ;
    endcase
    if (rd == '0) begin
      e_o.wreg = 1'b0;
    end
  end

  assign taken    = is_jal | (is_branch & ((src1 == src2) ^ func3[0]));
  assign target_o = d_i.pc + (is_jal ? imm_j : imm_b);

  // Load data only exists once the load reaches WB
  assign load_use = (fwd.ex_memrd && ((use_rs1 && ex_hit1) || (use_rs2 && ex_hit2))) ||
                    (fwd.mem_memrd && ((use_rs1 && mem_hit1) || (use_rs2 && mem_hit2)));

  assign mem_stall  = stallreq_imem_i | stallreq_dmem_i;
  assign redirect_o = taken & ~load_use & ~mem_stall;

  // Bit 0 is the PC, bits 1 to 4 the stage registers
  assign hold_o   = {{3{mem_stall}}, {2{mem_stall | load_use}}};
  assign bubble_o = {2'b00, load_use, redirect_o, 1'b0};

endmodule

`default_nettype wire

/* verilog/ifetch.sv */
`timescale 1ns/100ps
`default_nettype none

module ifetch (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      hold_i,
  input  logic                      redirect_i,
  input  logic [core_pkg::XLEN-1:0] target_i,
  input  logic [core_pkg::XLEN-1:0] inst_in_i,
  output logic                      inst_read_o,
  output logic [core_pkg::XLEN-1:0] inst_addr_o,
  output core_pkg::if_id_t          fetch_o
);
  import core_pkg::*;

  logic [XLEN-1:0] pc;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pc          <= '0;
      inst_read_o <= 1'b0;
    end else begin
      inst_read_o <= 1'b1;
      if (inst_read_o && !hold_i) begin
        pc <= redirect_i ? target_i : pc + XLEN'(4);
      end
    end
  end

  assign inst_addr_o = pc;

  // No read yet, so pass a bubble
  always_comb begin
    fetch_o = '0;
    if (inst_read_o) begin
      fetch_o.pc   = pc;
      fetch_o.inst = inst_in_i;
    end
  end

endmodule

`default_nettype wire

/* verilog/regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module regfile (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        we_i,
  input  logic [core_pkg::REG_AW-1:0] waddr_i,
  input  logic [core_pkg::XLEN-1:0]   wdata_i,
  input  logic [core_pkg::REG_AW-1:0] raddr1_i,
  input  logic [core_pkg::REG_AW-1:0] raddr2_i,
  output logic [core_pkg::XLEN-1:0]   rdata1_o,
  output logic [core_pkg::XLEN-1:0]   rdata2_o
);
  import core_pkg::*;

  logic [XLEN-1:0] regs [2**REG_AW];

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < 2**REG_AW; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // Write in WB is seen by decode in the same cycle
  assign rdata1_o = (raddr1_i == '0) ? '0 :
                    (we_i && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 :
                    (we_i && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

endmodule

`default_nettype wire

/* verilog/pipe_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rstn,
  input  logic     hold_i,
  input  logic     bubble_i,
  input  payload_t d_i,
  output payload_t q_o
);

  // All-zero payload is a no-op
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      q_o <= '0;
    end else if (!hold_i) begin
      if (bubble_i) begin
        q_o <= '0;
      end else begin
        q_o <= d_i;
      end
    end
  end

endmodule

`default_nettype wire

/* common/fwd_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface fwd_if;
  import core_pkg::*;

  logic              ex_wreg;
  logic [REG_AW-1:0] ex_rd;
  logic [XLEN-1:0]   ex_data;
  logic              ex_memrd;
  logic              mem_wreg;
  logic [REG_AW-1:0] mem_rd;
  logic [XLEN-1:0]   mem_data;
  logic              mem_memrd;

  modport src(output ex_wreg, ex_rd, ex_data, ex_memrd, mem_wreg, mem_rd, mem_data, mem_memrd);
  modport dst(input ex_wreg, ex_rd, ex_data, ex_memrd, mem_wreg, mem_rd, mem_data, mem_memrd);

endinterface

`default_nettype wire

/* common/core_pkg.sv */
`default_nettype none

package core_pkg;

  parameter int XLEN      = 32;
  parameter int REG_AW    = 5;
  parameter int STAGE_NUM = 5;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_t;

  // Major opcodes
  parameter logic [6:0] OP_REG    = 7'b0110011;
  parameter logic [6:0] OP_IMM    = 7'b0010011;
  parameter logic [6:0] OP_LOAD   = 7'b0000011;
  parameter logic [6:0] OP_STORE  = 7'b0100011;
  parameter logic [6:0] OP_BRANCH = 7'b1100011;
  parameter logic [6:0] OP_JAL    = 7'b1101111;

  // Memory access widths
  parameter logic [2:0] F3_B  = 3'b000;
  parameter logic [2:0] F3_W  = 3'b010;
  parameter logic [2:0] F3_BU = 3'b100;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst;
  } if_id_t;

  typedef struct packed {
    logic [XLEN-1:0]   pc;
    alu_op_t           alu_op;
    logic [XLEN-1:0]   op_a;
    logic [XLEN-1:0]   op_b;
    logic [XLEN-1:0]   store_data;
    logic [REG_AW-1:0] rd;
    logic              wreg;
    logic              memrd;
    logic              memwr;
    logic [2:0]        func3;
    logic              is_link;
  } id_ex_t;

  typedef struct packed {
    logic [XLEN-1:0]   result;
    logic [XLEN-1:0]   store_data;
    logic [REG_AW-1:0] rd;
    logic              wreg;
    logic              memrd;
    logic              memwr;
    logic [2:0]        func3;
  } ex_mem_t;

  typedef struct packed {
    logic [XLEN-1:0]   result;
    logic [REG_AW-1:0] rd;
    logic              wreg;
    logic              memrd;
    logic [2:0]        func3;
    logic [1:0]        addr_lo;
  } mem_wb_t;

endpackage

`default_nettype wire
